// File: run_sim.sh
#!/usr/bin/env bash
# Builds the core testbench with Verilator and runs it; the exit status follows the result.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module core_tb \
    -f sources.f -o core_sim &&
./obj_dir/core_sim | tee /dev/stderr | grep -qx "TEST OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: sim/core_patterns.hex
// program words in fetch order from address 0, then the marker word DEADBEEF,
// then one expected store per line as address and data, then the store count.
00500093 00C00113 002081B3 10302023
40208233 10402223 0020F2B3 10502423
0020E333 10602623 0020C3B3 10702823
12345437 10802A23 11402483 00148493
10902C23 00208463 10102E23 00209463
12202023 00108463 12202223 00109463
12202423 0080056F 12202623 12A02823
00000073
DEADBEEF
00000100 00000011
00000104 FFFFFFF9
00000108 00000004
0000010C 0000000D
00000110 00000009
00000114 12345000
00000118 12345001
0000011C 00000005
00000128 0000000C
00000130 00000068
0000000A

// File: sim/core_props.sv
// Wishbone protocol and halt assertions, bound to the core top level.
`default_nettype none

module core_props
    import core_bus_pkg::*;
(
    input logic    CLK,
    input logic    rst,
    input wb_req_t ibus_req,
    input wb_rsp_t ibus_rsp,
    input wb_req_t dbus_req,
    input wb_rsp_t dbus_rsp,
    input logic    halt
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;  // read by the testbench for its closing report.

    // a pending request holds every field until the slave acks it.
    ibus_stable: assert property (@(posedge CLK) disable iff (rst)
        ibus_req.stb && !ibus_rsp.ack |=> $stable(ibus_req))
        else begin
            $error("ibus request changed before ack");
            fail_count++;
        end

    dbus_stable: assert property (@(posedge CLK) disable iff (rst)
        dbus_req.stb && !dbus_rsp.ack |=> $stable(dbus_req))
        else begin
            $error("dbus request changed before ack");
            fail_count++;
        end

    stb_needs_cyc: assert property (@(posedge CLK)
        !(ibus_req.stb && !ibus_req.cyc) && !(dbus_req.stb && !dbus_req.cyc))
        else begin
            $error("stb high without cyc");
            fail_count++;
        end

    halt_sticky: assert property (@(posedge CLK) disable iff (rst) halt |=> halt)
        else begin
            $error("halt fell while out of reset");
            fail_count++;
        end

    // the first reset edge only clears the registers, so the check starts one edge later.
    idle_in_reset: assert property (@(posedge CLK)
        rst && $past(rst) |-> !ibus_req.cyc && !dbus_req.cyc)
        else begin
            $error("bus cycle active during reset");
            fail_count++;
        end

endmodule

bind core_no_memory core_props i_core_props (
    .CLK      (CLK),
    .rst      (rst),
    .ibus_req (ibus_req),
    .ibus_rsp (ibus_rsp),
    .dbus_req (dbus_req),
    .dbus_rsp (dbus_rsp),
    .halt     (halt)
);

`default_nettype wire

// File: sim/core_tb.sv
// Testbench for the two-stage core: program and data slaves, store checks, watchdog and report.
`default_nettype none

module core_tb
    import core_bus_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] MARKER    = 32'hDEAD_BEEF;  // separates program and expected stores.
    localparam int          PAT_WORDS = 128;
    localparam int          RAM_WORDS = 256;

    logic        CLK;
    logic        rst = 1'b1;
    wb_rsp_t     ibus_rsp = '0;
    wb_rsp_t     dbus_rsp = '0;
    wb_req_t     ibus_req;
    wb_req_t     dbus_req;
    logic        halt;

    logic [31:0] pat [PAT_WORDS];   // image of the pattern file.
    logic [31:0] dram [RAM_WORDS];  // word-addressed data RAM.
    logic [31:0] exp_adr [$];
    logic [31:0] exp_dat [$];
    logic [31:0] got_adr [$];       // stores of the current run.
    logic [31:0] got_dat [$];
    logic [31:0] first_adr [$];     // stores of the run with wait states.
    logic [31:0] first_dat [$];
    int          n_prog = 0;
    int          n_exp = 0;
    int          value_errors = 0;
    int          seq_errors = 0;
    int          prop_errors = 0;
    bit          zero_wait = 1'b0;
    bit          loaded = 1'b0;
    bit          i_busy = 1'b0;
    bit          d_busy = 1'b0;
    int          i_wait = 0;
    int          d_wait = 0;
    logic        i_cyc_q = 1'b0;
    logic        d_cyc_q = 1'b0;

    tb_clock_gen i_clock_gen (.CLK(CLK));

    core_no_memory i_core_no_memory (
        .CLK      (CLK),
        .rst      (rst),
        .ibus_rsp (ibus_rsp),
        .dbus_rsp (dbus_rsp),
        .ibus_req (ibus_req),
        .dbus_req (dbus_req),
        .halt     (halt)
    );

    // entries that the file did not write keep this index-dependent value.
    function automatic logic [31:0] unwritten(input int idx);
        return 32'hEE00_0000 | 32'(idx);
    endfunction

    function automatic logic [31:0] ram_fill(input int idx);
        return 32'hA500_0000 ^ 32'(idx << 2);  // every word differs, so stray loads show up.
    endfunction

    function automatic int pick_wait();
        if (zero_wait) return 0;
        return int'($urandom_range(3, 0));
    endfunction

    // words past the program read as zero and halt the core as an unknown opcode.
    function automatic logic [31:0] fetch_word(input logic [31:0] adr);
        if (adr < 32'(n_prog * 4)) return pat[adr[8:2]];
        return 32'h0;
    endfunction

    task automatic load_patterns();
        int mark;
        int last;
        for (int i = 0; i < PAT_WORDS; i++) pat[i] = unwritten(i);
        $readmemh("sim/core_patterns.hex", pat);
        mark = -1;
        for (int i = 0; i < PAT_WORDS; i++) begin
            if (mark < 0 && pat[i] == MARKER) mark = i;
        end
        if (mark < 1) begin
            seq_errors++;
            $display("the pattern file has no program or no marker word");
            return;
        end
        last = mark + 1;
        while (last < PAT_WORDS && pat[last] != unwritten(last)) last++;
        n_prog = mark;
        n_exp  = int'(pat[last - 1]);  // the count closes the file.
        if (last - mark - 2 != 2 * n_exp) begin
            seq_errors++;
            $display("the store count in the pattern file does not match its pairs");
            n_exp = 0;
        end
        for (int k = 0; k < n_exp; k++) begin
            exp_adr.push_back(pat[mark + 1 + 2 * k]);
            exp_dat.push_back(pat[mark + 2 + 2 * k]);
        end
    endtask

    // each store is checked in order at the moment the slave accepts it.
    task automatic check_store(input logic [31:0] adr, input logic [31:0] dat);
        int k;
        k = got_adr.size();
        got_adr.push_back(adr);
        got_dat.push_back(dat);
        if (k >= n_exp) begin
            seq_errors++;
            $display("extra store of %h to address %h at %0t ns", dat, adr, $time);
        end else begin
            if (adr != exp_adr[k]) begin
                value_errors++;
                $display("[ERROR] %0t ns dbus_req.adr expected %h actual %h",
                         $time, exp_adr[k], adr);
            end
            if (dat != exp_dat[k]) begin
                value_errors++;
                $display("[ERROR] %0t ns dbus_req.dat expected %h actual %h",
                         $time, exp_dat[k], dat);
            end
        end
    endtask

    // every access is a full word, so all four byte lanes must be enabled.
    task automatic check_sel(input string field, input logic [3:0] sel);
        if (sel != 4'hF) begin
            value_errors++;
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, field, 4'hF, sel);
        end
    endtask

    // instruction slave with 0 to 3 wait cycles.
    always @(negedge CLK) begin
        if (rst) begin
            ibus_rsp.ack = 1'b0;
            i_busy = 1'b0;
        end else if (ibus_rsp.ack) begin
            ibus_rsp.ack = 1'b0;  // the master drops cyc after the ack edge.
        end else if (ibus_req.cyc && ibus_req.stb) begin
            if (!i_busy) begin
                i_busy = 1'b1;
                i_wait = pick_wait();
            end
            if (i_wait == 0) begin
                ibus_rsp.ack = 1'b1;
                ibus_rsp.dat = fetch_word(ibus_req.adr);
                i_busy = 1'b0;
                if (ibus_req.we != 1'b0) begin
                    value_errors++;
                    $display("[ERROR] %0t ns ibus_req.we expected 0 actual %b",
                             $time, ibus_req.we);
                end
                check_sel("ibus_req.sel", ibus_req.sel);
            end else begin
                i_wait--;
            end
        end
    end

    // the data slave has the same timing and works on the data RAM.
    always @(negedge CLK) begin
        if (rst) begin
            dbus_rsp.ack = 1'b0;
            d_busy = 1'b0;
        end else if (dbus_rsp.ack) begin
            dbus_rsp.ack = 1'b0;
        end else if (dbus_req.cyc && dbus_req.stb) begin
            if (!d_busy) begin
                d_busy = 1'b1;
                d_wait = pick_wait();
            end
            if (d_wait == 0) begin
                dbus_rsp.ack = 1'b1;
                d_busy = 1'b0;
                check_sel("dbus_req.sel", dbus_req.sel);
                if (dbus_req.we) begin
                    dram[dbus_req.adr[9:2]] = dbus_req.dat;
                    check_store(dbus_req.adr, dbus_req.dat);
                end else begin
                    dbus_rsp.dat = dram[dbus_req.adr[9:2]];
                end
            end else begin
                d_wait--;
            end
        end
    end

    // a halted core must not open a new cycle on either bus.
    always @(negedge CLK) begin
        if (!rst && halt && ((ibus_req.cyc && !i_cyc_q) || (dbus_req.cyc && !d_cyc_q))) begin
            seq_errors++;
            $display("a bus cycle started while halt was high at %0t ns", $time);
        end
        i_cyc_q = ibus_req.cyc;
        d_cyc_q = dbus_req.cyc;
    end

    task automatic run_program(input bit no_wait);
        zero_wait = no_wait;
        got_adr.delete();
        got_dat.delete();
        for (int i = 0; i < RAM_WORDS; i++) dram[i] = ram_fill(i);
        rst = 1'b1;
        repeat (8) @(negedge CLK);
        rst = 1'b0;
        while (!halt) @(negedge CLK);  // the watchdog bounds this wait.
        repeat (20) @(negedge CLK);     // idle tail to catch late bus activity.
        if (!halt) begin
            seq_errors++;
            $display("halt fell after the final ecall");
        end
        if (got_adr.size() != n_exp) begin
            seq_errors++;
            $display("the program made %0d stores, but %0d were expected", got_adr.size(), n_exp);
        end
    endtask

    // the zero-wait run must repeat the first run store for store.
    task automatic compare_runs();
        if (first_adr.size() != got_adr.size()) begin
            seq_errors++;
            $display("the two runs made different numbers of stores");
            return;
        end
        for (int k = 0; k < got_adr.size(); k++) begin
            if (got_adr[k] != first_adr[k]) begin
                value_errors++;
                $display("[ERROR] %0t ns dbus_req.adr expected %h actual %h",
                         $time, first_adr[k], got_adr[k]);
            end
            if (got_dat[k] != first_dat[k]) begin
                value_errors++;
                $display("[ERROR] %0t ns dbus_req.dat expected %h actual %h",
                         $time, first_dat[k], got_dat[k]);
            end
        end
    endtask

    // every instruction makes at most one data access, which bounds both runs.
    initial begin
        int limit;
        wait (loaded);
        limit = 2 * (40 * n_prog + 40 * n_prog) + 80;
        repeat (limit) @(posedge CLK);
        $display("watchdog expired after %0d cycles without reaching the end", limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int seed;
        seed = $urandom(32'h4ba7);
        load_patterns();
        loaded = 1'b1;
        run_program(1'b0);
        first_adr = got_adr;
        first_dat = got_dat;
        run_program(1'b1);
        compare_runs();
        prop_errors = i_core_no_memory.i_core_props.fail_count;
        $display("errors: %0d value, %0d sequence, %0d assertion",
                 value_errors, seq_errors, prop_errors);
        if (value_errors + seq_errors + prop_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
// Testbench clock generator with a 4 ns period.
`default_nettype none

module tb_clock_gen (
    output logic CLK
);
    timeunit 1ns;
    timeprecision 100ps;

    initial CLK = 1'b0;  // the first rising edge comes at 2 ns.
    always #2 CLK = ~CLK;

endmodule

`default_nettype wire

// File: source/core_bus_pkg.sv
// Bus and pipeline types of the core: Wishbone request and response, stage latch and hazard controls.
`default_nettype none

package core_bus_pkg;
    import rv_isa_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;  // address of the first fetch.

    // wishbone classic master request; both buses use it.
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [XLEN-1:0]   adr;
        logic [XLEN-1:0]   dat;
        logic [XLEN/8-1:0] sel;  // byte lanes, always all ones here.
    } wb_req_t;

    // wishbone slave response.
    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] dat;
    } wb_rsp_t;

    // the latch between fetch and execute.
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetch_exec_t;

    // controls from the hazard unit back to fetch.
    typedef struct packed {
        logic            stall;
        logic            flush;
        logic            redirect;
        logic [XLEN-1:0] target;
    } hazard_t;

endpackage

`default_nettype wire

// File: source/core_no_memory.sv
// Top level of the two-stage RV32I core with Wishbone instruction and data master ports.
`default_nettype none

module core_no_memory
    import core_bus_pkg::*;
(
    input  logic    CLK,
    input  logic    rst,
    input  wb_rsp_t ibus_rsp,
    input  wb_rsp_t dbus_rsp,
    output wb_req_t ibus_req,
    output wb_req_t dbus_req,
    output logic    halt
);
    fetch_exec_t fe;             // the latch between the stages.
    hazard_t     hz;
    logic        mem_busy;
    logic        branch_taken;
    logic [31:0] branch_target;

    fetch_stage i_fetch_stage (
        .CLK      (CLK),
        .rst      (rst),
        .hz       (hz),
        .ibus_rsp (ibus_rsp),
        .ibus_req (ibus_req),
        .fe       (fe)
    );

    execute_stage i_execute_stage (
        .CLK           (CLK),
        .rst           (rst),
        .fe            (fe),
        .dbus_rsp      (dbus_rsp),
        .dbus_req      (dbus_req),
        .mem_busy      (mem_busy),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .halted        (halt)  // the sticky halt flag is the core output.
    );

    hazard_unit i_hazard_unit (
        .mem_busy      (mem_busy),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .halted        (halt),
        .hz            (hz)
    );

endmodule

`default_nettype wire

// File: source/execute_stage.sv
// Execute stage: decode, ALU, branch resolution, data bus access and register write-back.
`default_nettype none

module execute_stage
    import rv_isa_pkg::*;
    import core_bus_pkg::*;
(
    input  logic        CLK,
    input  logic        rst,
    input  fetch_exec_t fe,
    input  wb_rsp_t     dbus_rsp,
    output wb_req_t     dbus_req,
    output logic        mem_busy,
    output logic        branch_taken,
    output logic [31:0] branch_target,
    output logic        halted
);
    typedef enum logic {BUS_READY, BUS_RECOVER} bus_state_t;  // recover keeps cyc low one cycle.

    opcode_t         opcode;
    alu_op_t         alu_op;
    bus_state_t      bus_state;
    logic [4:0]      rd, rs1, rs2;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] rs1_val, rs2_val, alu_a, alu_b, alu_res, wdata;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic            is_lui, is_jal, is_branch, is_load, is_store, is_alu, is_stop;
    logic            cond, live, mem_req, bus_cyc, bus_done, wen, halted_q;

    function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic sub);
        case (f3)
            F3_ADD_SUB: return sub ? ALU_SUB : ALU_ADD;
            F3_XOR:     return ALU_XOR;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;  // other funct3 codes are outside the subset.
        endcase
    endfunction

    assign opcode = opcode_t'(fe.instr[OPCODE_LSB +: 7]);
    assign rd     = fe.instr[RD_LSB +: 5];
    assign rs1    = fe.instr[RS1_LSB +: 5];
    assign rs2    = fe.instr[RS2_LSB +: 5];
    assign funct3 = fe.instr[FUNCT3_LSB +: 3];
    assign funct7 = fe.instr[FUNCT7_LSB +: 7];
    assign imm_i  = {{20{fe.instr[31]}}, fe.instr[31:20]};
    assign imm_s  = {{20{fe.instr[31]}}, fe.instr[31:25], fe.instr[11:7]};
    assign imm_b  = {{19{fe.instr[31]}}, fe.instr[31], fe.instr[7], fe.instr[30:25],
                     fe.instr[11:8], 1'b0};
    assign imm_u  = {fe.instr[31:12], 12'b0};
    assign imm_j  = {{11{fe.instr[31]}}, fe.instr[31], fe.instr[19:12], fe.instr[20],
                     fe.instr[30:21], 1'b0};

    // the decode picks the instruction class and the ALU operands.
    always_comb begin
        {is_lui, is_jal, is_branch, is_load, is_store, is_alu, is_stop} = '0;
        alu_op = ALU_ADD;  // loads and stores add base and offset.
        alu_a  = rs1_val;
        alu_b  = imm_i;
        case (opcode)
            OPC_LUI: begin
                is_lui = 1'b1;
                alu_op = ALU_PASS_B;
                alu_b  = imm_u;
            end
            OPC_JAL: begin
                is_jal = 1'b1;
                alu_a  = fe.pc;  // the link value is pc plus four.
                alu_b  = 32'd4;
            end
            OPC_BRANCH: is_branch = 1'b1;
            OPC_LOAD: begin
                is_load = funct3 == F3_WORD;
                is_stop = funct3 != F3_WORD;  // byte and half loads are not supported.
            end
            OPC_STORE: begin
                is_store = funct3 == F3_WORD;
                is_stop  = funct3 != F3_WORD;
                alu_b    = imm_s;
            end
            OPC_OP_IMM: begin
                is_alu = 1'b1;
                alu_op = alu_decode(funct3, 1'b0);  // there is no subtract immediate.
            end
            OPC_OP: begin
                is_alu = 1'b1;
                alu_op = alu_decode(funct3, funct7 == F7_SUB);
                alu_b  = rs2_val;
            end
            OPC_SYSTEM: is_stop = 1'b1;  // ecall.
            default:    is_stop = 1'b1;  // an unknown opcode stops the core like ecall.
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SUB:    alu_res = alu_a - alu_b;
            ALU_AND:    alu_res = alu_a & alu_b;
            ALU_OR:     alu_res = alu_a | alu_b;
            ALU_XOR:    alu_res = alu_a ^ alu_b;
            ALU_PASS_B: alu_res = alu_b;
            default:    alu_res = alu_a + alu_b;
        endcase
        case (funct3)
            F3_BEQ:  cond = rs1_val == rs2_val;
            F3_BNE:  cond = rs1_val != rs2_val;
            default: cond = 1'b0;  // unsupported compares fall through.
        endcase
    end

    assign live          = fe.valid & ~halted_q;  // nothing retires once halted.
    assign mem_req       = live & (is_load | is_store);
    assign bus_cyc       = mem_req & (bus_state == BUS_READY);
    assign bus_done      = bus_cyc & dbus_rsp.ack;
    assign mem_busy      = mem_req & ~bus_done;  // fetch holds the latch until the ack.
    assign branch_taken  = live & (is_jal | (is_branch & cond));
    assign branch_target = fe.pc + (is_jal ? imm_j : imm_b);
    assign halted        = halted_q | (live & is_stop);  // high from the ecall cycle on.
    assign wen           = live & (is_alu | is_lui | is_jal | (is_load & bus_done));
    assign wdata         = is_load ? dbus_rsp.dat : alu_res;
    assign dbus_req      = '{cyc: bus_cyc, stb: bus_cyc, we: is_store, adr: alu_res,
                             dat: rs2_val, sel: '1};

    always_ff @(posedge CLK) begin
        if (rst) begin
            bus_state <= BUS_READY;
            halted_q  <= 1'b0;
        end else begin
            halted_q <= halted;  // sticky.
            case (bus_state)
                BUS_READY:   if (bus_done) bus_state <= BUS_RECOVER;
                default:     bus_state <= BUS_READY;
            endcase
        end
    end

    register_file i_register_file (
        .CLK    (CLK),
        .rst    (rst),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .wen    (wen),
        .wdata  (wdata),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
// Fetch stage: program counter, one outstanding instruction read and the fetch-to-execute latch.
`default_nettype none

module fetch_stage
    import core_bus_pkg::*;
(
    input  logic        CLK,
    input  logic        rst,
    input  hazard_t     hz,
    input  wb_rsp_t     ibus_rsp,
    output wb_req_t     ibus_req,
    output fetch_exec_t fe
);
    logic [31:0] pc;          // address of the next word to fetch.
    logic [31:0] i_adr;       // address of the read on the bus.
    logic        i_cyc;
    logic        discard;     // the read in flight belongs to a squashed path.
    logic        skid_valid;
    logic [31:0] skid_pc;
    logic [31:0] skid_instr;
    logic        fe_valid;
    logic [31:0] fe_pc;
    logic [31:0] fe_instr;
    logic        accept;
    logic        issue;

    assign accept = i_cyc & ibus_rsp.ack & ~discard & ~hz.redirect;  // word kept.
    assign issue  = ~i_cyc & ~skid_valid & ~hz.stall;  // the bus is idle one cycle after each ack.

    always_ff @(posedge CLK) begin
        if (rst) begin
            pc         <= RESET_PC;
            i_cyc      <= 1'b0;
            discard    <= 1'b0;
            skid_valid <= 1'b0;
            fe_valid   <= 1'b0;
        end else begin
            if (hz.redirect) pc <= hz.target;
            else if (accept) pc <= pc + 32'd4;
            if (i_cyc) i_cyc <= ~ibus_rsp.ack;  // cyc drops right after the ack.
            else i_cyc <= issue;
            if (i_cyc & ibus_rsp.ack) discard <= 1'b0;
            else if (i_cyc & hz.redirect) discard <= 1'b1;  // finish the read, drop the word.
            if (hz.flush) skid_valid <= 1'b0;
            else if (accept & hz.stall) skid_valid <= 1'b1;  // execute is busy, park the word.
            else if (~hz.stall) skid_valid <= 1'b0;
            if (hz.flush) fe_valid <= 1'b0;
            else if (~hz.stall) fe_valid <= skid_valid | accept;  // execute consumed the old one.
        end
    end

    // payload registers follow their valid bits.
    always_ff @(posedge CLK) begin
        if (issue) i_adr <= hz.redirect ? hz.target : pc;  // a redirect fetches its target at once.
        if (accept & hz.stall) begin
            skid_pc    <= i_adr;
            skid_instr <= ibus_rsp.dat;
        end
        if (~hz.stall) begin
            fe_pc    <= skid_valid ? skid_pc : i_adr;
            fe_instr <= skid_valid ? skid_instr : ibus_rsp.dat;
        end
    end

    assign ibus_req = '{cyc: i_cyc, stb: i_cyc, we: 1'b0, adr: i_adr, dat: '0, sel: '1};
    assign fe       = '{valid: fe_valid, pc: fe_pc, instr: fe_instr};

endmodule

`default_nettype wire

// File: source/hazard_unit.sv
// Hazard unit: turns execute-stage status into stall, flush and redirect for the fetch stage.
`default_nettype none

module hazard_unit
    import core_bus_pkg::*;
(
    input  logic        mem_busy,
    input  logic        branch_taken,
    input  logic [31:0] branch_target,
    input  logic        halted,
    output hazard_t     hz
);

    // a data access in flight or a halted core freezes fetch.
    // a taken branch or jump squashes the latch and steers fetch to the target;
    // it overrides any stall raised in the same cycle.
    assign hz = '{
        stall:    (mem_busy | halted) & ~branch_taken,
        flush:    branch_taken,
        redirect: branch_taken,
        target:   branch_target
    };

endmodule

`default_nettype wire

// File: source/register_file.sv
// Integer register file: 32 registers of 32 bits, two asynchronous reads and one synchronous write.
`default_nettype none

module register_file (
    input  logic        CLK,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        wen,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);
    logic [31:0] regs [32];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;  // every register starts at zero.
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= wdata;  // x0 ignores writes.
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: source/rv_isa_pkg.sv
// RV32I instruction-set definitions: opcodes, ALU operations and instruction field positions.
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;  // integer register and data path width.

    // bit positions of the fixed fields in a 32-bit instruction word.
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    // funct3 values for the supported subset.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_WORD    = 3'b010;  // lw and sw share it.
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // major opcodes, bits 6:0 of the instruction.
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    // operations of the single ALU in the execute stage.
    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B} alu_op_t;

endpackage

`default_nettype wire

// File: sources.f
source/rv_isa_pkg.sv
source/core_bus_pkg.sv
source/register_file.sv
source/hazard_unit.sv
source/fetch_stage.sv
source/execute_stage.sv
source/core_no_memory.sv
sim/tb_clock_gen.sv
sim/core_props.sv
sim/core_tb.sv
